/* Makefile */
# Verilator build and run of the aes-128 serial engine testbench

VERILATOR ?= verilator
TOP ?= aes128_spi_tb
FILE_LIST ?= aes128_spi.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --assert --timing -j 0
RUN_ARGS ?= +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@grep -q "Test OK" $(LOG) || (echo "simulation did not finish"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* aes128_spi.f */
logic/aes_pkg.sv
logic/aes_sbox_rom.sv
logic/aes_round_path.sv
logic/aes_key_expand.sv
logic/aes_core.sv
logic/aes_spi_link.sv
logic/aes128_spi.sv
testbench/aes128_spi_checker.sv
testbench/aes128_spi_tb.sv

/* logic/aes128_spi.sv */
// top level of the aes-128 serial engine
// serial link in front, iterative cipher core behind it
module aes128_spi (
	input logic clk,
	input logic reset,
	input logic sck,
	input logic sdi,
	input logic load,
	output logic sdo,
	output logic done
);
	import aes_pkg::*;

	// one-cycle start on load fall
	logic start;
	// input shifter halves
	block_t plaintext;
	block_t key;
	// final state from the core
	block_t ciphertext;

	// sck/sdi/load sync, shift in, shift out
	aes_spi_link aes_spi_link_i (
		.clk(clk),
		.reset(reset),
		.sck(sck),
		.sdi(sdi),
		.load(load),
		.done(done),
		.ciphertext(ciphertext),
		.start(start),
		.plaintext(plaintext),
		.key(key),
		.sdo(sdo)
	);

	// ten rounds, done holds until the next start
	aes_core aes_core_i (
		.clk(clk),
		.reset(reset),
		.start(start),
		.plaintext(plaintext),
		.key(key),
		.done(done),
		.ciphertext(ciphertext)
	);

endmodule

/* logic/aes_core.sv */
// aes-128 round sequencer
// FSM stepping IDLE, LOOKUP/COMBINE per round, DONE
// holds the cipher state and round key registers
module aes_core (
	input logic clk,
	input logic reset,
	input logic start,
	input aes_pkg::block_t plaintext,
	input aes_pkg::block_t key,
	output logic done,
	output aes_pkg::block_t ciphertext
);
	import aes_pkg::*;

	core_state_t fsm;
	// current round, 1 to NUM_ROUNDS while busy
	round_t round;
	// cipher state between rounds
	block_t state_reg;
	// key for the round just finished
	block_t key_reg;
	// results of the round and key paths, valid in COMBINE
	block_t state_next;
	block_t key_next;
	// start only counts when not busy
	logic accept;
	logic last_round;

	assign accept = start && (fsm == IDLE || fsm == DONE);
	// final round skips the column mix
	assign last_round = (round == round_t'(NUM_ROUNDS));

	////////////////////////////////////////////////////////////
	// sequencer

	always_ff @(posedge clk) begin
		if (reset) begin
			fsm <= IDLE;
			round <= '0;
		end else begin
			case (fsm)
				IDLE, DONE: begin
					if (accept) begin
						fsm <= LOOKUP;
						round <= round_t'(1);
					end
				end
				// s-box registers read here
				LOOKUP: begin
					fsm <= COMBINE;
				end
				COMBINE: begin
					if (last_round) begin
						fsm <= DONE;
					end else begin
						fsm <= LOOKUP;
						round <= round + round_t'(1);
					end
				end
				default: begin
					fsm <= IDLE;
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// state and round key

	always_ff @(posedge clk) begin
		if (accept) begin
			// initial add round key
			state_reg <= plaintext ^ key;
			key_reg <= key;
		end else if (fsm == COMBINE) begin
			state_reg <= state_next;
			key_reg <= key_next;
		end
	end

	// sub bytes, shift rows, mix columns, add next key
	aes_round_path aes_round_path_i (
		.clk(clk),
		.state_in(state_reg),
		.round_key_next(key_next),
		.last_round(last_round),
		.state_out(state_next)
	);

	// key schedule one step ahead of the state
	aes_key_expand aes_key_expand_i (
		.clk(clk),
		.round_key(key_reg),
		.round(round),
		.next_key(key_next)
	);

	assign ciphertext = state_reg;
	// level, drops once the next start is taken
	assign done = (fsm == DONE);

endmodule

/* logic/aes_key_expand.sv */
// aes-128 key schedule step
// rot word, 4 registered s-box lookups, rcon and the word chain
module aes_key_expand (
	input logic clk,
	input aes_pkg::block_t round_key,
	input aes_pkg::round_t round,
	output aes_pkg::block_t next_key
);
	import aes_pkg::*;

	// w3 rotated left by one byte
	word_t rot_word;
	// substituted, one cycle after round_key
	word_t sub_word;

	// words are w0 in 127:96 down to w3 in 31:0
	assign rot_word = {round_key[23:0], round_key[31:24]};

	for (genvar i = 0; i < 4; i++) begin : g_sbox
		aes_sbox_rom aes_sbox_rom_i (
			.clk(clk),
			.addr(rot_word[31 - 8*i -: 8]),
			.data(sub_word[31 - 8*i -: 8])
		);
	end

	////////////////////////////////////////////////////////////
	// word chain

	// round must hold through the lookup cycle
	assign next_key[127:96] = round_key[127:96] ^ sub_word ^ rcon(round);
	// each word folds in the new word before it
	assign next_key[95:64] = round_key[95:64] ^ next_key[127:96];
	assign next_key[63:32] = round_key[63:32] ^ next_key[95:64];
	assign next_key[31:0] = round_key[31:0] ^ next_key[63:32];

endmodule

/* logic/aes_pkg.sv */
// shared widths and types for the aes-128 serial engine
// round count, field constant, transfer size, core latency
// rcon and xtime helpers for the key schedule and column mix
package aes_pkg;

	////////////////////////////////////////////////////////////
	// types

	// 16 bytes column-major, byte 0 in bits 127:120
	typedef logic [127:0] block_t;
	// one column or one key word
	typedef logic [31:0] word_t;
	typedef logic [7:0] byte_t;
	// round number, 0 to 10
	typedef logic [3:0] round_t;

	// core sequencer states
	typedef enum logic [1:0] {
		IDLE,
		LOOKUP,
		COMBINE,
		DONE
	} core_state_t;

	////////////////////////////////////////////////////////////
	// constants

	localparam int NUM_ROUNDS = 10;
	// x^8 + x^4 + x^3 + x + 1 with the top bit dropped
	localparam byte_t GF_POLY = 8'h1b;
	// plaintext then key
	localparam int SPI_IN_BITS = 256;
	// start pulse to done, one load cycle plus two per round
	localparam int CORE_LATENCY = 21;

	////////////////////////////////////////////////////////////
	// field helpers

	// multiply by x, reduce when bit 7 falls off
	function automatic byte_t xtime(input byte_t b);
		byte_t shifted;
		shifted = {b[6:0], 1'b0};
		return b[7] ? (shifted ^ GF_POLY) : shifted;
	endfunction

	// round constant x^(round-1) in the top byte
	function automatic word_t rcon(input round_t round);
		byte_t c;
		c = 8'h01;
		// fixed bound, doubling only up to the asked round
		for (int i = 2; i <= NUM_ROUNDS; i++) begin
			if (i <= int'(round)) begin
				c = xtime(c);
			end
		end
		return {c, 24'h000000};
	endfunction

endpackage

/* logic/aes_round_path.sv */
// one aes cipher round
// 16 registered s-box lookups, row shift, column mix, key add
// column mix is skipped on the last round
module aes_round_path (
	input logic clk,
	input aes_pkg::block_t state_in,
	input aes_pkg::block_t round_key_next,
	input logic last_round,
	output aes_pkg::block_t state_out
);
	import aes_pkg::*;

	// s-box outputs, one cycle after state_in
	block_t sub_state;
	block_t shift_state;
	block_t mix_state;

	////////////////////////////////////////////////////////////
	// sub bytes

	// byte i sits in bits 127-8i down
	for (genvar i = 0; i < 16; i++) begin : g_sbox
		aes_sbox_rom aes_sbox_rom_i (
			.clk(clk),
			.addr(state_in[127 - 8*i -: 8]),
			.data(sub_state[127 - 8*i -: 8])
		);
	end

	////////////////////////////////////////////////////////////
	// shift rows

	// byte index is 4*column + row, row r rotates left by r
	always_comb begin
		for (int c = 0; c < 4; c++) begin
			for (int r = 0; r < 4; r++) begin
				shift_state[127 - 8*(4*c + r) -: 8] =
					sub_state[127 - 8*(4*((c + r) % 4) + r) -: 8];
			end
		end
	end

	////////////////////////////////////////////////////////////
	// mix columns

	// y_r = a_r ^ sum ^ 2*(a_r ^ a_r+1), same as the 2-3-1-1 matrix
	always_comb begin
		byte_t a [4];
		byte_t sum;
		for (int c = 0; c < 4; c++) begin
			for (int r = 0; r < 4; r++) begin
				a[r] = shift_state[127 - 8*(4*c + r) -: 8];
			end
			sum = a[0] ^ a[1] ^ a[2] ^ a[3];
			for (int r = 0; r < 4; r++) begin
				mix_state[127 - 8*(4*c + r) -: 8] =
					a[r] ^ sum ^ xtime(a[r] ^ a[(r + 1) % 4]);
			end
		end
	end

	// add round key
	assign state_out = (last_round ? shift_state : mix_state) ^ round_key_next;

endmodule

/* logic/aes_sbox_rom.sv */
// aes s-box as a 256 by 8 rom
// registered read, contents from the hex table
module aes_sbox_rom (
	input logic clk,
	input aes_pkg::byte_t addr,
	output aes_pkg::byte_t data
);
	import aes_pkg::*;

	byte_t rom [256];

	// 16 bytes per line, path relative to the project root
	initial begin
		$readmemh("logic/sbox.hex", rom);
	end

	// maps onto block ram
	always_ff @(posedge clk) begin
		data <= rom[addr];
	end

endmodule

/* logic/aes_spi_link.sv */
// serial link in the clk domain
// two-flop synchronizers and edge detect for sck, sdi and load
// 256-bit input shifter, ciphertext capture and the output shifter
module aes_spi_link (
	input logic clk,
	input logic reset,
	input logic sck,
	input logic sdi,
	input logic load,
	input logic done,
	input aes_pkg::block_t ciphertext,
	output logic start,
	output aes_pkg::block_t plaintext,
	output aes_pkg::block_t key,
	output logic sdo
);
	import aes_pkg::*;

	// bit 1 is the settled copy
	logic [1:0] sck_sync;
	logic [1:0] sdi_sync;
	logic [1:0] load_sync;
	// one cycle behind the settled copies
	logic sck_d;
	logic load_d;
	logic done_d;
	// edge strobes
	logic sck_rise;
	logic sck_fall;
	logic done_rise;
	// plaintext in the top half, key in the bottom half
	logic [SPI_IN_BITS-1:0] in_shift;
	// ciphertext on its way out, msb first
	block_t out_shift;

	////////////////////////////////////////////////////////////
	// synchronizers and edge detect

	always_ff @(posedge clk) begin
		if (reset) begin
			sck_sync <= '0;
			sdi_sync <= '0;
			load_sync <= '0;
			sck_d <= 1'b0;
			load_d <= 1'b0;
			done_d <= 1'b0;
			start <= 1'b0;
		end else begin
			sck_sync <= {sck_sync[0], sck};
			sdi_sync <= {sdi_sync[0], sdi};
			load_sync <= {load_sync[0], load};
			sck_d <= sck_sync[1];
			load_d <= load_sync[1];
			// done comes from the core, already in this domain
			done_d <= done;
			// registered pulse on the settled load fall
			start <= load_d & ~load_sync[1];
		end
	end

	// sdi goes through the same depth, so it lines up with sck
	assign sck_rise = sck_sync[1] & ~sck_d;
	assign sck_fall = ~sck_sync[1] & sck_d;
	assign done_rise = done & ~done_d;

	////////////////////////////////////////////////////////////
	// input shifter

	// mode 0, sample on sck rise, only while load is high
	always_ff @(posedge clk) begin
		if (load_sync[1] && sck_rise) begin
			in_shift <= {in_shift[SPI_IN_BITS-2:0], sdi_sync[1]};
		end
	end

	// first 128 bits shifted in end up on top
	assign plaintext = in_shift[SPI_IN_BITS-1 -: $bits(block_t)];
	assign key = in_shift[$bits(block_t)-1:0];

	////////////////////////////////////////////////////////////
	// output shifter

	always_ff @(posedge clk) begin
		if (reset) begin
			out_shift <= '0;
		end else if (done_rise) begin
			out_shift <= ciphertext;
		end else if (sck_fall) begin
			// next bit shows after each sck fall
			out_shift <= {out_shift[$bits(block_t)-2:0], 1'b0};
		end
	end

	// bypass while the capture is in flight, so bit 127 is there with done
	assign sdo = done_rise ? ciphertext[$bits(block_t)-1] : out_shift[$bits(block_t)-1];

endmodule

/* logic/sbox.hex */
// aes s-box, line = high nibble of the input byte, column = low nibble
63 7c 77 7b f2 6b 6f c5 30 01 67 2b fe d7 ab 76
ca 82 c9 7d fa 59 47 f0 ad d4 a2 af 9c a4 72 c0
b7 fd 93 26 36 3f f7 cc 34 a5 e5 f1 71 d8 31 15
04 c7 23 c3 18 96 05 9a 07 12 80 e2 eb 27 b2 75
09 83 2c 1a 1b 6e 5a a0 52 3b d6 b3 29 e3 2f 84
53 d1 00 ed 20 fc b1 5b 6a cb be 39 4a 4c 58 cf
d0 ef aa fb 43 4d 33 85 45 f9 02 7f 50 3c 9f a8
51 a3 40 8f 92 9d 38 f5 bc b6 da 21 10 ff f3 d2
cd 0c 13 ec 5f 97 44 17 c4 a7 7e 3d 64 5d 19 73
60 81 4f dc 22 2a 90 88 46 ee b8 14 de 5e 0b db
e0 32 3a 0a 49 06 24 5c c2 d3 ac 62 91 95 e4 79
e7 c8 37 6d 8d d5 4e a9 6c 56 f4 ea 65 7a ae 08
ba 78 25 2e 1c a6 b4 c6 e8 dd 74 1f 4b bd 8b 8a
70 3e b5 66 48 03 f6 0e 61 35 57 b9 86 c1 1d 9e
e1 f8 98 11 69 d9 8e 94 9b 1e 87 e9 ce 55 28 df
8c a1 89 0d bf e6 42 68 41 99 2d 0f b0 54 bb 16

/* testbench/aes128_spi_checker.sv */
// concurrent timing checks for the aes-128 serial engine
// core latency, done release, sdo update timing
module aes128_spi_checker (
	input logic clk,
	input logic reset,
	input logic start,
	input logic done,
	input logic sck_fall,
	input logic sdo
);
	import aes_pkg::*;

	// count of failed properties, read at the end of the run
	int failures = 0;

	////////////////////////////////////////////////////////////
	// core timing

	// every done rise traces back to a start
	a_latency: assert property (@(posedge clk) disable iff (reset)
		$rose(done) |-> $past(start, CORE_LATENCY))
	else begin
		$error("done rose without a start %0d cycles earlier", CORE_LATENCY);
		failures++;
	end

	// a new start releases done right away
	a_done_release: assert property (@(posedge clk) disable iff (reset)
		start |=> !done)
	else begin
		$error("done still high the cycle after start");
		failures++;
	end

	////////////////////////////////////////////////////////////
	// link output

	// sdo moves only after a detected sck fall, or with the ciphertext capture
	a_sdo_timing: assert property (@(posedge clk) disable iff (reset)
		$changed(sdo) |-> ($past(sck_fall) || $rose(done)))
	else begin
		$error("sdo changed without a preceding sck fall");
		failures++;
	end

endmodule

// start and done at the link are the core's own ports
bind aes_spi_link aes128_spi_checker link_checker_i (
	.clk(clk),
	.reset(reset),
	.start(start),
	.done(done),
	.sck_fall(sck_fall),
	.sdo(sdo)
);

/* testbench/aes128_spi_tb.sv */
// testbench for the aes-128 serial engine
// clock, reset, serial driver tasks and directed fips-197 vectors
// cycle timeout and the final verdict
module aes128_spi_tb;
	import aes_pkg::*;

	// whole run, seven transactions of at most about 5500 cycles, one cut short
	localparam int TIMEOUT_CYCLES = 40000;
	// sync, edge detect and the core itself
	localparam int DONE_LIMIT = CORE_LATENCY + 16;

	logic clk;
	logic reset;
	logic sck;
	logic sdi;
	logic load;
	logic sdo;
	logic done;

	// sck timing jitter source
	logic [31:0] rng_state = 32'h7cc86195;
	int cycles = 0;

	aes128_spi aes128_spi_i (
		.clk(clk),
		.reset(reset),
		.sck(sck),
		.sdi(sdi),
		.load(load),
		.sdo(sdo),
		.done(done)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// helpers

	task automatic stop_on_failure(input string msg);
		$display("%s", msg);
		$display("Test FAILED");
		$fatal(1, "run stopped at the first failure");
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			stop_on_failure("timeout, the run did not finish within the cycle limit");
		end else if (aes128_spi_i.aes_spi_link_i.link_checker_i.failures != 0) begin
			stop_on_failure("a timing assertion in the checker failed");
		end
	end

	// xorshift32
	function automatic logic [31:0] next_random();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	// 4 to 7 clk per sck phase
	function automatic int pick_half_period();
		return 4 + int'(next_random() % 32'd4);
	endfunction

	task automatic hold(input int n);
		repeat (n) @(posedge clk);
	endtask

	////////////////////////////////////////////////////////////
	// serial driver

	// plaintext then key, msb first, sdi set while sck is low
	task automatic send_block(input block_t pt, input block_t key_in, input bit expect_idle);
		logic [SPI_IN_BITS-1:0] frame;
		frame = {pt, key_in};
		@(posedge clk);
		load <= 1'b1;
		for (int i = SPI_IN_BITS - 1; i >= 0; i--) begin
			sdi <= frame[i];
			hold(pick_half_period());
			sck <= 1'b1;
			hold(pick_half_period());
			sck <= 1'b0;
			if (expect_idle) begin
				@(negedge clk);
				assert (done == 1'b0)
				else stop_on_failure("done went high while the first block was shifted in");
				@(posedge clk);
			end
		end
		hold(pick_half_period());
		load <= 1'b0;
		sdi <= 1'b0;
	endtask

	// a stale done must drop first, then the new one must rise
	task automatic wait_done();
		int waited;
		waited = 0;
		@(negedge clk);
		while (done) begin
			waited++;
			assert (waited < DONE_LIMIT)
			else stop_on_failure("done did not drop after the new block was loaded");
			@(negedge clk);
		end
		waited = 0;
		while (!done) begin
			waited++;
			assert (waited < DONE_LIMIT)
			else stop_on_failure("done did not rise after the block was loaded");
			@(negedge clk);
		end
	endtask

	// sdo sampled on the clk fall just before each sck fall
	task automatic read_block(input int nbits, output block_t got);
		got = '0;
		for (int i = 0; i < nbits; i++) begin
			@(posedge clk);
			sck <= 1'b1;
			hold(pick_half_period() - 1);
			@(negedge clk);
			got[127 - i] = sdo;
			@(posedge clk);
			sck <= 1'b0;
			hold(pick_half_period());
		end
	endtask

	task automatic run_vector(input string name, input block_t pt, input block_t key_in,
		input block_t expected, input int nbits, input bit expect_idle);
		block_t got;
		block_t mask;
		send_block(pt, key_in, expect_idle);
		wait_done();
		// first ciphertext bit shows with done, before any readout sck
		assert (sdo == expected[127])
		else stop_on_failure($sformatf("error %s sdo at done: expected %b, actual %b",
			name, expected[127], sdo));
		read_block(nbits, got);
		// only the bits actually read are compared
		mask = '1;
		mask = ~(mask >> nbits);
		assert ((got & mask) == (expected & mask))
		else stop_on_failure($sformatf("error %s: expected %h, actual %h",
			name, expected & mask, got & mask));
	endtask

	////////////////////////////////////////////////////////////
	// directed tests

	task automatic test_reset_values();
		hold(2);
		@(negedge clk);
		assert (done == 1'b0)
		else stop_on_failure("done is high after reset");
		assert (sdo == 1'b0)
		else stop_on_failure("sdo is high after reset");
	endtask

	// fips-197 appendix b, done watched during the shift
	task automatic test_fips_b();
		run_vector("fips197_b", 128'h3243f6a8885a308d313198a2e0370734,
			128'h2b7e151628aed2a6abf7158809cf4f3c,
			128'h3925841d02dc09fbdc118597196a0b32, 128, 1'b1);
	endtask

	// fips-197 appendix c.1
	task automatic test_fips_c1();
		run_vector("fips197_c1", 128'h00112233445566778899aabbccddeeff,
			128'h000102030405060708090a0b0c0d0e0f,
			128'h69c4e0d86a7b0430d8cdb78070b4c55a, 128, 1'b0);
	endtask

	task automatic test_all_zero();
		run_vector("all_zero", '0, '0, 128'h66e94bd4ef8a2c3b884cfa59ca342b2e, 128, 1'b0);
	endtask

	// short readout, then new blocks with no reset in between
	task automatic test_back_to_back();
		run_vector("cut_c1", 128'h00112233445566778899aabbccddeeff,
			128'h000102030405060708090a0b0c0d0e0f,
			128'h69c4e0d86a7b0430d8cdb78070b4c55a, 40, 1'b0);
		// sp 800-38a ecb block 2, top ciphertext bit set so sdo at done moves
		run_vector("sp800_38a_b2", 128'hae2d8a571e03ac9c9eb76fac45af8e51,
			128'h2b7e151628aed2a6abf7158809cf4f3c,
			128'hf5d3d58503b9699de785895a96fdbaaf, 128, 1'b0);
		run_vector("again_b", 128'h3243f6a8885a308d313198a2e0370734,
			128'h2b7e151628aed2a6abf7158809cf4f3c,
			128'h3925841d02dc09fbdc118597196a0b32, 128, 1'b0);
		run_vector("again_zero", '0, '0, 128'h66e94bd4ef8a2c3b884cfa59ca342b2e, 128, 1'b0);
	endtask

	////////////////////////////////////////////////////////////
	// main sequence

	initial begin
		reset = 1'b1;
		sck = 1'b0;
		sdi = 1'b0;
		load = 1'b0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;

		test_reset_values();
		test_fips_b();
		test_fips_c1();
		test_all_zero();
		test_back_to_back();

		hold(4);
		if (aes128_spi_i.aes_spi_link_i.link_checker_i.failures == 0) begin
			$display("Test OK");
			$finish;
		end else begin
			stop_on_failure("one or more timing assertions in the checker failed");
		end
	end

endmodule
